// File: bit_queue/bit_queue.sv
`timescale 1ns/1ns

module bit_queue import h261_pkg::*; (
    input  logic      clk50,
    input  logic      reset,
    input  logic      run,
    input  ram_word_t word,
    input  logic      word_valid,
    output logic      word_req,
    bit_window_if.queue win
);

    window_t   window_q;
    fill_t     fill;         // valid bits from the top down
    skip_len_t shift_left;   // shifts still owed to the parser
    logic      in_flight;    // word requested, not yet delivered
    logic      shifting;
    fill_t     fill_after;   // fill once this cycle's shift is applied
    window_t   shifted;
    window_t   appended;

    assign shifting   = (shift_left != '0);
    assign shifted    = shifting ? (window_q << 1) : window_q;
    assign fill_after = shifting ? (fill - 1'b1) : fill;

    // new word lands right under the last valid bit
    assign appended = {word, {(QUEUE_BITS - WORD_BITS){1'b0}}} >> fill_after;

    assign win.window = window_q;
    assign win.valid  = (fill >= fill_t'(LOOK_BITS)) && !shifting;
    assign word_req   = (fill <= fill_t'(QUEUE_BITS - WORD_BITS)) && !in_flight;

    // bits under the fill stay zero so the append can be an or
    always_ff @(posedge clk50 or posedge reset) begin
        if (reset) begin
            window_q   <= '0;
            fill       <= '0;
            shift_left <= '0;
            in_flight  <= 1'b0;
        end else if (run) begin
            if (word_valid) begin
                window_q <= shifted | appended;   // shift first, then append
                fill     <= fill_after + fill_t'(WORD_BITS);
            end else begin
                window_q <= shifted;
                fill     <= fill_after;
            end

            if (win.consume)
                shift_left <= win.consume_len;     // window is idle when this comes
            else if (shifting)
                shift_left <= shift_left - 1'b1;

            if (word_valid)
                in_flight <= 1'b0;
            else if (word_req)
                in_flight <= 1'b1;
        end
    end

    // refill threshold plus one outstanding word keeps this bounded
    assert property (@(posedge clk50) disable iff (reset)
        fill <= fill_t'(QUEUE_BITS));

    assert property (@(posedge clk50) disable iff (reset)
        win.consume |-> win.valid);

endmodule

// File: bit_queue/ram_reader.sv
`timescale 1ns/1ns

module ram_reader import h261_pkg::*; #(
    parameter ram_addr_t START_ADDR = '0
) (
    input  logic      clk50,
    input  logic      reset,
    input  logic      run,
    input  logic      word_req,     // pulse from the queue
    input  ram_word_t ram_data,
    input  logic      ram_ack,
    output logic      ram_rden,
    output ram_addr_t ram_addr,
    output ram_word_t word,         // earlier stream byte on top
    output logic      word_valid,   // one-cycle pulse
    output logic      refilling
);

    typedef enum logic [1:0] {rd_idle, rd_req, rd_wait_low} rd_state_t;

    rd_state_t state;
    logic      req_pend;   // request that came in while the bus was busy

    assign ram_rden  = (state == rd_req);   // held until the ack cycle
    assign refilling = (state != rd_idle);

    always_ff @(posedge clk50 or posedge reset) begin
        if (reset) begin
            state      <= rd_idle;
            ram_addr   <= START_ADDR;
            req_pend   <= 1'b0;
            word_valid <= 1'b0;
        end else if (run) begin
            word_valid <= 1'b0;
            if (word_req)
                req_pend <= 1'b1;
            case (state)
                rd_idle: if (word_req || req_pend) begin
                    state    <= rd_req;
                    req_pend <= 1'b0;
                end
                rd_req: if (ram_ack) begin   // data is taken this cycle
                    state      <= rd_wait_low;
                    ram_addr   <= ram_addr + 1'b1;
                    word_valid <= 1'b1;
                end
                rd_wait_low: if (!ram_ack)
                    state <= rd_idle;        // bus released, next request may go
                default: state <= rd_idle;
            endcase
        end
    end

    // low byte of the memory word is the earlier one in the stream
    always_ff @(posedge clk50) begin
        if (run && state == rd_req && ram_ack)
            word <= {ram_data[7:0], ram_data[15:8]};
    end

    // address must not move under a pending request
    assert property (@(posedge clk50) disable iff (reset)
        (ram_rden && !ram_ack) |=> $stable(ram_addr));

endmodule

// File: common/bit_window_if.sv
`timescale 1ns/1ns

// window view from the bit queue, consume requests back from the parser
interface bit_window_if import h261_pkg::*; ();

    window_t   window;       // top bit is next in the stream
    logic      valid;        // enough bits and no shift in progress
    logic      consume;      // one-cycle pulse, only while valid
    skip_len_t consume_len;  // bits to drop

    modport queue (
        output window, valid,
        input  consume, consume_len
    );

    modport parser (
        input  window, valid,
        output consume, consume_len
    );

endinterface

// File: common/h261_pkg.sv
package h261_pkg;

    // window and memory geometry
    localparam int QUEUE_BITS = 48;
    localparam int WORD_BITS  = 16;
    localparam int LOOK_BITS  = 32;   // fill needed before the parser may look

    typedef logic [24:0]            ram_addr_t;   // external word address
    typedef logic [WORD_BITS-1:0]   ram_word_t;
    typedef logic [QUEUE_BITS-1:0]  window_t;     // bit 47 is the oldest bit
    typedef logic [5:0]             fill_t;       // 0..48 valid bits
    typedef logic [5:0]             skip_len_t;   // bits to drop in one consume

    // decoded header fields
    typedef logic [4:0] tr_t;
    typedef logic [3:0] gn_t;
    typedef logic [4:0] gquant_t;
    typedef logic [5:0] mba_t;          // 1..33
    typedef logic [3:0] mtype_flags_t;  // {mquant, mvd, cbp, tcoeff}

    // start codes and fixed patterns
    localparam logic [19:0] PSC_CODE   = 20'h00010;
    localparam logic [15:0] GBSC_CODE  = 16'h0001;
    localparam logic [5:0]  PTYPE_QCIF = 6'b001011;   // qcif, freeze released
    localparam skip_len_t   PTYPE_SKIP  = 6'd7;       // ptype + pei bit
    localparam skip_len_t   GQUANT_SKIP = 6'd6;       // gquant + gei bit

    typedef enum logic [3:0] {
        ps_psc,
        ps_tr,
        ps_ptype,
        ps_gbsc,
        ps_gn,
        ps_gquant,
        ps_mba,
        ps_mtype,
        ps_skip,    // waiting for the window to settle after a consume
        ps_done,
        ps_error
    } parse_state_t;

endpackage

// File: h261_header_top.f
common/h261_pkg.sv
common/bit_window_if.sv
bit_queue/ram_reader.sv
bit_queue/bit_queue.sv
header_parser/vlc_decode.sv
header_parser/header_parser.sv
verilog/h261_header_top.sv
verif/h261_header_tb.sv

// File: header_parser/header_parser.sv
`timescale 1ns/1ns

module header_parser import h261_pkg::*; (
    input  logic         clk50,
    input  logic         reset,
    input  logic         run,
    bit_window_if.parser win,
    output logic         hdr_done,
    output logic         parse_error,
    output tr_t          tr,
    output gn_t          gn,
    output gquant_t      gquant,
    output mba_t         mba,
    output mtype_flags_t mtype_flags
);

    parse_state_t state;
    parse_state_t ret_state;   // where ps_skip goes once the window is back
    parse_state_t ret_next;
    logic         parsing;     // state looks at a field
    logic         field_ok;
    skip_len_t    field_len;
    mba_t         vlc_mba;
    skip_len_t    mba_len;
    logic         mba_ok;
    mtype_flags_t vlc_flags;
    skip_len_t    mtype_len;
    logic         mtype_ok;

    vlc_decode vlc_decode_i (
        .bits        (win.window[QUEUE_BITS-1 -: 11]),
        .mba         (vlc_mba),
        .mba_len     (mba_len),
        .mba_ok      (mba_ok),
        .mtype_flags (vlc_flags),
        .mtype_len   (mtype_len),
        .mtype_ok    (mtype_ok)
    );

    // field check and length for the current state
    always_comb begin
        parsing   = 1'b1;
        field_ok  = 1'b1;
        field_len = '0;
        ret_next  = ps_error;
        case (state)
            ps_psc: begin
                field_ok  = (win.window[QUEUE_BITS-1 -: $bits(PSC_CODE)] == PSC_CODE);
                field_len = skip_len_t'($bits(PSC_CODE));
                ret_next  = ps_tr;
            end
            ps_tr: begin
                field_len = skip_len_t'($bits(tr_t));
                ret_next  = ps_ptype;
            end
            ps_ptype: begin     // pei must be 0 or the gbsc check fails later
                field_ok  = (win.window[QUEUE_BITS-1 -: $bits(PTYPE_QCIF)] == PTYPE_QCIF);
                field_len = PTYPE_SKIP;
                ret_next  = ps_gbsc;
            end
            ps_gbsc: begin
                field_ok  = (win.window[QUEUE_BITS-1 -: $bits(GBSC_CODE)] == GBSC_CODE);
                field_len = skip_len_t'($bits(GBSC_CODE));
                ret_next  = ps_gn;
            end
            ps_gn: begin
                field_len = skip_len_t'($bits(gn_t));
                ret_next  = ps_gquant;
            end
            ps_gquant: begin
                field_len = GQUANT_SKIP;   // gei dropped with it
                ret_next  = ps_mba;
            end
            ps_mba: begin
                field_ok  = mba_ok;
                field_len = mba_len;
                ret_next  = ps_mtype;
            end
            ps_mtype: begin
                field_ok  = mtype_ok;
                field_len = mtype_len;
                ret_next  = ps_done;       // stop after the first macroblock type
            end
            default: parsing = 1'b0;
        endcase
    end

    assign win.consume     = run && win.valid && parsing && field_ok;
    assign win.consume_len = field_len;
    assign hdr_done        = (state == ps_done);
    assign parse_error     = (state == ps_error);

    always_ff @(posedge clk50 or posedge reset) begin
        if (reset) begin
            state     <= ps_psc;
            ret_state <= ps_psc;
        end else if (run) begin
            if (parsing && win.valid) begin
                ret_state <= ret_next;
                state     <= field_ok ? ps_skip : ps_error;
            end else if (state == ps_skip && win.valid) begin
                state <= ret_state;   // shifts done and window refilled
            end
        end
    end

    // capture on the consume that drops the field
    always_ff @(posedge clk50) begin
        if (win.consume) begin
            case (state)
                ps_tr:     tr          <= win.window[QUEUE_BITS-1 -: $bits(tr_t)];
                ps_gn:     gn          <= win.window[QUEUE_BITS-1 -: $bits(gn_t)];
                ps_gquant: gquant      <= win.window[QUEUE_BITS-1 -: $bits(gquant_t)];
                ps_mba:    mba         <= vlc_mba;
                ps_mtype:  mtype_flags <= vlc_flags;
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk50) disable iff (reset)
        !(hdr_done && parse_error));

endmodule

// File: header_parser/vlc_decode.sv
`timescale 1ns/1ns

module vlc_decode import h261_pkg::*; (
    input  logic [10:0]  bits,          // top of the window, oldest bit first
    output mba_t         mba,
    output skip_len_t    mba_len,
    output logic         mba_ok,
    output mtype_flags_t mtype_flags,
    output skip_len_t    mtype_len,
    output logic         mtype_ok
);

    logic [12:0] mba_dec;     // {ok, address, length}
    logic [10:0] mtype_dec;   // {ok, flags, length}

    assign {mba_ok, mba, mba_len}           = mba_dec;
    assign {mtype_ok, mtype_flags, mtype_len} = mtype_dec;

    always_comb begin
        casez (bits)
            11'b1??????????: mba_dec = {1'b1, 6'd1, 6'd1};
            11'b011????????: mba_dec = {1'b1, 6'd2, 6'd3};
            11'b010????????: mba_dec = {1'b1, 6'd3, 6'd3};
            11'b0011???????: mba_dec = {1'b1, 6'd4, 6'd4};
            11'b0010???????: mba_dec = {1'b1, 6'd5, 6'd4};
            11'b00011??????: mba_dec = {1'b1, 6'd6, 6'd5};
            11'b00010??????: mba_dec = {1'b1, 6'd7, 6'd5};
            11'b0000111????: mba_dec = {1'b1, 6'd8, 6'd7};
            11'b0000110????: mba_dec = {1'b1, 6'd9, 6'd7};
            11'b00001011???: mba_dec = {1'b1, 6'd10, 6'd8};
            11'b00001010???: mba_dec = {1'b1, 6'd11, 6'd8};
            11'b00001001???: mba_dec = {1'b1, 6'd12, 6'd8};
            11'b00001000???: mba_dec = {1'b1, 6'd13, 6'd8};
            11'b00000111???: mba_dec = {1'b1, 6'd14, 6'd8};
            11'b00000110???: mba_dec = {1'b1, 6'd15, 6'd8};
            11'b0000010111?: mba_dec = {1'b1, 6'd16, 6'd10};
            11'b0000010110?: mba_dec = {1'b1, 6'd17, 6'd10};
            11'b0000010101?: mba_dec = {1'b1, 6'd18, 6'd10};
            11'b0000010100?: mba_dec = {1'b1, 6'd19, 6'd10};
            11'b0000010011?: mba_dec = {1'b1, 6'd20, 6'd10};
            11'b0000010010?: mba_dec = {1'b1, 6'd21, 6'd10};
            11'b00000100011: mba_dec = {1'b1, 6'd22, 6'd11};
            11'b00000100010: mba_dec = {1'b1, 6'd23, 6'd11};
            11'b00000100001: mba_dec = {1'b1, 6'd24, 6'd11};
            11'b00000100000: mba_dec = {1'b1, 6'd25, 6'd11};
            11'b00000011111: mba_dec = {1'b1, 6'd26, 6'd11};
            11'b00000011110: mba_dec = {1'b1, 6'd27, 6'd11};
            11'b00000011101: mba_dec = {1'b1, 6'd28, 6'd11};
            11'b00000011100: mba_dec = {1'b1, 6'd29, 6'd11};
            11'b00000011011: mba_dec = {1'b1, 6'd30, 6'd11};
            11'b00000011010: mba_dec = {1'b1, 6'd31, 6'd11};
            11'b00000011001: mba_dec = {1'b1, 6'd32, 6'd11};
            11'b00000011000: mba_dec = {1'b1, 6'd33, 6'd11};
            // stuffing 0000 0001 111 falls in here too, treated as an error
            default:         mba_dec = {1'b0, 6'd0, 6'd0};
        endcase
    end

    // flags are {mquant, mvd, cbp, tcoeff}
    always_comb begin
        casez (bits[10:1])
            10'b1?????????: mtype_dec = {1'b1, 4'b0011, 6'd1};    // inter
            10'b01????????: mtype_dec = {1'b1, 4'b0111, 6'd2};    // inter+mc+fil
            10'b001???????: mtype_dec = {1'b1, 4'b0100, 6'd3};    // inter+mc+fil, no coeffs
            10'b0001??????: mtype_dec = {1'b1, 4'b0001, 6'd4};    // intra
            10'b00001?????: mtype_dec = {1'b1, 4'b1011, 6'd5};    // inter+mquant
            10'b000001????: mtype_dec = {1'b1, 4'b1111, 6'd6};    // inter+mc+fil+mquant
            10'b0000001???: mtype_dec = {1'b1, 4'b1001, 6'd7};    // intra+mquant
            10'b00000001??: mtype_dec = {1'b1, 4'b0111, 6'd8};    // inter+mc
            10'b000000001?: mtype_dec = {1'b1, 4'b0100, 6'd9};    // inter+mc, no coeffs
            10'b0000000001: mtype_dec = {1'b1, 4'b1111, 6'd10};   // inter+mc+mquant
            default:        mtype_dec = {1'b0, 4'b0000, 6'd0};
        endcase
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module h261_header_tb \
    -f h261_header_top.f -o h261_header_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/h261_header_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

// File: verif/h261_header_tb.sv
`timescale 1ns/1ns

module h261_header_tb import h261_pkg::*; ();

    // stream variants
    localparam logic [2:0] CLEAN     = 3'd0;
    localparam logic [2:0] BAD_PSC   = 3'd1;
    localparam logic [2:0] CIF_PTYPE = 3'd2;
    localparam logic [2:0] PEI_SET   = 3'd3;
    localparam logic [2:0] RUN_HELD  = 3'd4;   // run low for 20 cycles after reset

    typedef struct packed {
        tr_t          tr;
        gn_t          gn;
        gquant_t      gquant;
        logic [10:0]  mba_code;   // right aligned in mba_len bits
        logic [3:0]   mba_len;
        mba_t         mba_exp;
        logic [9:0]   mt_code;
        logic [3:0]   mt_len;
        mtype_flags_t mt_flags;
        logic [2:0]   mode;
        logic         exp_err;
    } test_t;

    logic         clk50 = 1'b0;
    logic         reset;
    logic         run;
    ram_word_t    ram_data = '0;
    logic         ram_ack = 1'b0;
    logic         ram_rden;
    ram_addr_t    ram_addr;
    logic         refilling;
    logic         hdr_done;
    logic         parse_error;
    tr_t          tr;
    gn_t          gn;
    gquant_t      gquant;
    mba_t         mba;
    mtype_flags_t mtype_flags;

    test_t       tests[$];
    string       names[$];
    string       cur_name = "";    // test in progress
    logic [0:255] stream_bits;     // bit 0 is the first stream bit
    int          bit_pos;
    ram_word_t   mem [0:31];
    logic [31:0] lfsr = 32'h649a;
    logic [2:0]  delay_bits;
    logic [2:0]  ack_wait;
    logic        mem_busy = 1'b0;
    logic        rden_seen;        // rden was high on the previous edge
    ram_addr_t   next_addr;        // address the next request must use
    ram_addr_t   held_addr;
    int          err_count = 0;
    int          pass_count = 0;

    h261_header_top h261_header_top_i (
        .clk50, .reset, .run, .ram_data, .ram_ack,
        .ram_rden, .ram_addr, .refilling, .hdr_done, .parse_error,
        .tr, .gn, .gquant, .mba, .mtype_flags
    );

    initial forever #5 clk50 = ~clk50;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois step shifting right
    endfunction

    // unused words carry a pattern of the full address
    function automatic ram_word_t fill_word(input ram_addr_t a);
        return a[15:0] ^ {a[24:16], a[6:0]};
    endfunction

    function automatic ram_word_t read_word(input ram_addr_t a);
        if (a < 25'd32)
            return mem[a[4:0]];
        return fill_word(a);
    endfunction

    // memory answers each request after a random wait with one ack cycle
    always @(posedge clk50) begin
        if (reset) begin
            ram_ack  <= 1'b0;
            mem_busy <= 1'b0;
        end else if (ram_ack) begin
            ram_ack <= 1'b0;
        end else if (ram_rden && !mem_busy) begin
            for (int i = 0; i < 3; i++) begin
                delay_bits = {delay_bits[1:0], lfsr[0]};   // one step per bit
                lfsr = lfsr_step(lfsr);
            end
            ack_wait <= delay_bits;
            mem_busy <= 1'b1;
        end else if (mem_busy) begin
            if (ack_wait == 3'd0) begin
                ram_ack  <= 1'b1;
                ram_data <= read_word(ram_addr);
                mem_busy <= 1'b0;
            end else
                ack_wait <= ack_wait - 3'd1;
        end
    end

    // request address order and stability
    always @(posedge clk50) begin
        if (reset) begin
            rden_seen <= 1'b0;
            next_addr <= '0;
            held_addr <= '0;
        end else begin
            if (ram_rden && !rden_seen && ram_addr != next_addr) begin
                $display("Mismatch %0s request address: expected %0d, actual %0d",
                         cur_name, next_addr, ram_addr);
                err_count++;
            end
            if (ram_rden && rden_seen && ram_addr != held_addr) begin
                $display("Mismatch %0s address under request: expected %0d, actual %0d",
                         cur_name, held_addr, ram_addr);
                err_count++;
            end
            if (ram_rden && !refilling) begin
                $display("Mismatch %0s refilling during request: expected 1, actual 0",
                         cur_name);
                err_count++;
            end
            if (ram_rden && ram_ack && run)
                next_addr <= ram_addr + 25'd1;   // word taken
            rden_seen <= ram_rden;
            held_addr <= ram_addr;
        end
    end

    task automatic put_bits(input logic [31:0] val, input int len);
        for (int i = len - 1; i >= 0; i--) begin
            stream_bits[bit_pos] = val[i];   // msb first
            bit_pos++;
        end
    endtask

    task automatic build_stream(input test_t t);
        stream_bits = '1;   // ones after the header
        bit_pos = 0;
        if (t.mode == BAD_PSC)
            put_bits(32'(PSC_CODE ^ 20'h00100), 20);   // one bit set in the zero run
        else
            put_bits(32'(PSC_CODE), 20);
        put_bits(32'(t.tr), 5);
        if (t.mode == CIF_PTYPE)
            put_bits(32'b001111, 6);   // source format says cif
        else
            put_bits(32'(PTYPE_QCIF), 6);
        if (t.mode == PEI_SET) begin
            put_bits(32'd1, 1);
            put_bits(32'h5a, 8);       // pspare pushes gbsc down
        end
        put_bits(32'd0, 1);            // pei
        put_bits(32'(GBSC_CODE), 16);
        put_bits(32'(t.gn), 4);
        put_bits(32'(t.gquant), 5);
        put_bits(32'd0, 1);            // gei
        put_bits(32'(t.mba_code), int'(t.mba_len));
        put_bits(32'(t.mt_code), int'(t.mt_len));
        for (int a = 0; a < 32; a++)
            mem[a] = fill_word(ram_addr_t'(a));
        // earlier byte goes in the low half
        for (int w = 0; w < 16; w++)
            mem[w] = {stream_bits[16*w+8 +: 8], stream_bits[16*w +: 8]};
    endtask

    task automatic check_value(input string name, input string field,
                               input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch %0s %0s: expected %0d, actual %0d",
                     name, field, expected, actual);
            err_count++;
        end
    endtask

    task automatic add_test(input string name, input test_t t);
        names.push_back(name);
        tests.push_back(t);
    endtask

    task automatic run_one_test(input string name, input test_t t);
        int errs_before;
        int cycles;
        errs_before = err_count;
        cur_name = name;
        @(posedge clk50);
        reset <= 1'b1;
        run   <= (t.mode != RUN_HELD);
        build_stream(t);
        repeat (3) @(posedge clk50);
        reset <= 1'b0;
        if (t.mode == RUN_HELD) begin
            repeat (20) begin
                @(negedge clk50);
                if (ram_rden || refilling || hdr_done || parse_error) begin
                    $display("test %0s: DUT became active while run was low", name);
                    err_count++;
                end
            end
            @(posedge clk50);
            run <= 1'b1;
        end
        cycles = 0;
        while (!hdr_done && !parse_error && cycles < 2000) begin
            @(negedge clk50);
            cycles++;
        end
        if (!hdr_done && !parse_error) begin
            $display("test %0s: neither hdr_done nor parse_error came within 2000 cycles",
                     name);
            err_count++;
        end else if (t.exp_err) begin
            check_value(name, "parse_error", 1, int'(parse_error));
            check_value(name, "hdr_done", 0, int'(hdr_done));
        end else begin
            check_value(name, "hdr_done", 1, int'(hdr_done));
            check_value(name, "parse_error", 0, int'(parse_error));
            check_value(name, "tr", int'(t.tr), int'(tr));
            check_value(name, "gn", int'(t.gn), int'(gn));
            check_value(name, "gquant", int'(t.gquant), int'(gquant));
            check_value(name, "mba", int'(t.mba_exp), int'(mba));
            check_value(name, "mtype_flags", int'(t.mt_flags), int'(mtype_flags));
        end
        if (err_count == errs_before)
            pass_count++;
        $display("test %0s: %0s", name, (err_count == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        reset = 1'b1;
        run   = 1'b0;
        // name, then tr gn gquant | mba code len addr | mtype code len flags | mode err
        add_test("short_codes", '{5'd17, 4'd1, 5'd12, 11'b1, 4'd1, 6'd1,
                                  10'b0001, 4'd4, 4'b0001, CLEAN, 1'b0});
        add_test("mba22_inter_mc", '{5'd3, 4'd3, 5'd31, 11'b00000100011, 4'd11, 6'd22,
                                     10'b00000001, 4'd8, 4'b0111, CLEAN, 1'b0});
        add_test("mba33_mc_no_coef", '{5'd30, 4'd5, 5'd1, 11'b00000011000, 4'd11, 6'd33,
                                       10'b000000001, 4'd9, 4'b0100, CLEAN, 1'b0});
        add_test("mba27_mc_mquant", '{5'd0, 4'd12, 5'd20, 11'b00000011110, 4'd11, 6'd27,
                                      10'b0000000001, 4'd10, 4'b1111, CLEAN, 1'b0});
        add_test("mba25_intra_mquant", '{5'd9, 4'd3, 5'd7, 11'b00000100000, 4'd11, 6'd25,
                                         10'b0000001, 4'd7, 4'b1001, CLEAN, 1'b0});
        add_test("bad_psc", '{5'd4, 4'd1, 5'd8, 11'b1, 4'd1, 6'd1,
                              10'b0001, 4'd4, 4'b0001, BAD_PSC, 1'b1});
        add_test("ptype_cif", '{5'd4, 4'd1, 5'd8, 11'b1, 4'd1, 6'd1,
                                10'b0001, 4'd4, 4'b0001, CIF_PTYPE, 1'b1});
        add_test("pei_set", '{5'd4, 4'd1, 5'd8, 11'b1, 4'd1, 6'd1,
                              10'b0001, 4'd4, 4'b0001, PEI_SET, 1'b1});
        add_test("mba_stuffing", '{5'd6, 4'd5, 5'd9, 11'b00000001111, 4'd11, 6'd0,
                                   10'b0001, 4'd4, 4'b0001, CLEAN, 1'b1});
        add_test("mba_all_zero", '{5'd6, 4'd5, 5'd9, 11'b0, 4'd11, 6'd0,
                                   10'b0001, 4'd4, 4'b0001, CLEAN, 1'b1});
        add_test("run_held", '{5'd17, 4'd1, 5'd12, 11'b1, 4'd1, 6'd1,
                               10'b0001, 4'd4, 4'b0001, RUN_HELD, 1'b0});
        foreach (tests[i])
            run_one_test(names[i], tests[i]);
        $display("tests: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests.size(), pass_count, tests.size() - pass_count, err_count);
        if (err_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: verilog/h261_header_top.sv
`timescale 1ns/1ns

module h261_header_top import h261_pkg::*; #(
    parameter ram_addr_t START_ADDR = '0
) (
    input  logic         clk50,
    input  logic         reset,
    input  logic         run,          // low freezes everything
    input  ram_word_t    ram_data,
    input  logic         ram_ack,
    output logic         ram_rden,
    output ram_addr_t    ram_addr,
    output logic         refilling,
    output logic         hdr_done,
    output logic         parse_error,
    output tr_t          tr,
    output gn_t          gn,
    output gquant_t      gquant,
    output mba_t         mba,
    output mtype_flags_t mtype_flags
);

    logic      word_req;
    ram_word_t word;
    logic      word_valid;

    bit_window_if bw ();

    // memory words into the window
    ram_reader #(.START_ADDR(START_ADDR)) ram_reader_i (
        .clk50, .reset, .run,
        .word_req, .ram_data, .ram_ack,
        .ram_rden, .ram_addr,
        .word, .word_valid, .refilling
    );

    bit_queue bit_queue_i (
        .clk50, .reset, .run,
        .word, .word_valid, .word_req,
        .win (bw.queue)
    );

    // window into the header fields
    header_parser header_parser_i (
        .clk50, .reset, .run,
        .win (bw.parser),
        .hdr_done, .parse_error,
        .tr, .gn, .gquant, .mba, .mtype_flags
    );

endmodule
